//--- verilog/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// Datapath widths
`define DATA_WIDTH      32
`define INST_ADDR_WIDTH 32
`define DATA_ADDR_WIDTH 10          // Byte address into the data memory
`define MEM_WORDS       256         // Depth of the data memory in words

// Memory access codes, funct3 encoding
`define ACC_B  3'd0                 // Signed byte
`define ACC_H  3'd1                 // Signed half
`define ACC_W  3'd2                 // Word
`define ACC_BU 3'd4                 // Unsigned byte
`define ACC_HU 3'd5                 // Unsigned half

// Register write-back select
`define WB_ALU 2'd0
`define WB_MEM 2'd1
`define WB_PC4 2'd2

// AXI response codes
`define AXI_OKAY   2'b00
`define AXI_SLVERR 2'b10

`endif

//--- verilog/Types.sv
`include "rv_consts.svh"

package Types;

    // ------------------------------
    // Vector types
    // ------------------------------

    typedef logic [`DATA_WIDTH-1:0]       Data;       // Data word
    typedef logic [`INST_ADDR_WIDTH-1:0]  InstAddr;   // Program counter
    typedef logic [`DATA_ADDR_WIDTH-1:0]  DataAddr;   // Byte address
    typedef logic [$clog2(`MEM_WORDS)-1:0] WordIndex; // Word index into memory
    typedef logic [`DATA_WIDTH/8-1:0]     ByteStrobe; // One bit per byte lane
    typedef logic [2:0]                   MemAccess;  // Access size and sign
    typedef logic [1:0]                   WbSel;      // Write-back source
    typedef logic [1:0]                   AxiResp;    // AXI response code

    // ------------------------------
    // State machines
    // ------------------------------

    // Host port transaction sequence
    typedef enum logic [1:0] {
        HOST_IDLE,
        HOST_WAIT_GRANT,
        HOST_WAIT_ACK,
        HOST_RESP
    } HostState;

    // Outstanding access of the memory stage
    typedef enum logic {
        STAGE_IDLE,
        STAGE_WAIT_ACK
    } StageState;

endpackage

//--- verilog/StageMEM.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module StageMEM
    import Types::*;
(
    input  logic      i_clock,
    input  logic      i_rst,

    input  logic      i_valid,          // Instruction present this cycle
    input  InstAddr   i_pc,
    input  Data       i_result,         // ALU result, byte address for memory ops
    input  Data       i_dataB,          // Store data
    input  logic      i_memRdEnable,    // Load
    input  logic      i_memWrEnable,    // Store
    input  MemAccess  i_memAccess,      // Size and sign of the access
    input  WbSel      i_regWrDataSel,   // Write-back source

    output Data       o_regWrData,      // Value for the destination register
    output logic      o_done,
    output logic      o_stall,          // Upstream holds its inputs

    // Memory request side
    output logic      o_memReq,
    output WordIndex  o_memAddr,
    output logic      o_memWrEnable,
    output ByteStrobe o_memWrStrobe,
    output Data       o_memWrData,
    input  logic      i_memGnt,
    input  logic      i_memAck,
    input  Data       i_memRdData);

    StageState   state;
    DataAddr     byteAddr;
    logic [1:0]  byteOff;               // Lane offset inside the word
    logic        memOp;
    logic [7:0]  ldByte;
    logic [15:0] ldHalf;
    Data         loadData;
    InstAddr     pcPlus4;

    assign byteAddr = i_result[`DATA_ADDR_WIDTH-1:0];
    assign byteOff  = byteAddr[1:0];
    assign memOp    = i_memRdEnable | i_memWrEnable;

    // ------------------------------
    // Access tracking
    // ------------------------------

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state <= STAGE_IDLE;
        end else begin
            case (state)
                STAGE_IDLE:     if (o_memReq && i_memGnt) state <= STAGE_WAIT_ACK;
                STAGE_WAIT_ACK: if (i_memAck) state <= STAGE_IDLE;
                default:        state <= STAGE_IDLE;
            endcase
        end
    end

    assign o_memReq = (state == STAGE_IDLE) & i_valid & memOp;      // Held until granted
    assign o_stall  = o_memReq | ((state == STAGE_WAIT_ACK) & ~i_memAck);
    assign o_done   = ((state == STAGE_IDLE) & i_valid & ~memOp)   // No memory, same cycle
                    | ((state == STAGE_WAIT_ACK) & i_memAck);

    // ------------------------------
    // Store lane placement
    // ------------------------------

    assign o_memAddr     = byteAddr[`DATA_ADDR_WIDTH-1:2];
    assign o_memWrEnable = i_memWrEnable;

    always_comb begin
        case (i_memAccess)
            `ACC_B, `ACC_BU: begin
                o_memWrStrobe = ByteStrobe'(4'b0001 << byteOff);
                o_memWrData   = {4{i_dataB[7:0]}};    // Replicate into every lane
            end
            `ACC_H, `ACC_HU: begin
                o_memWrStrobe = ByteStrobe'(4'b0011 << byteOff);
                o_memWrData   = {2{i_dataB[15:0]}};
            end
            default: begin
                o_memWrStrobe = 4'b1111;
                o_memWrData   = i_dataB;
            end
        endcase
    end

    // Load extraction and extension
    assign ldByte = i_memRdData[byteOff*8 +: 8];
    assign ldHalf = i_memRdData[byteOff[1]*16 +: 16];

    always_comb begin
        case (i_memAccess)
            `ACC_B:  loadData = {{24{ldByte[7]}}, ldByte};
            `ACC_BU: loadData = {24'h000000, ldByte};
            `ACC_H:  loadData = {{16{ldHalf[15]}}, ldHalf};
            `ACC_HU: loadData = {16'h0000, ldHalf};
            `ACC_W:  loadData = i_memRdData;
            default: loadData = i_memRdData;
        endcase
    end

    // Write-back source
    assign pcPlus4 = i_pc + InstAddr'(4);

    always_comb begin
        case (i_regWrDataSel)
            `WB_ALU: o_regWrData = i_result;
            `WB_MEM: o_regWrData = loadData;      // Valid in the ack cycle
            `WB_PC4: o_regWrData = Data'(pcPlus4);
            default: o_regWrData = i_result;
        endcase
    end

    // Half and word accesses on natural boundaries
    assert property (@(posedge i_clock) disable iff (i_rst)
        (i_valid && memOp) |->
            !((i_memAccess[0] && byteOff[0]) || (i_memAccess[1] && byteOff != 2'b00)));

    // Upstream keeps the operands still while stalled
    assert property (@(posedge i_clock) disable iff (i_rst)
        o_stall |=> $stable(i_result) && $stable(i_memAccess) && $stable(i_dataB));

endmodule

//--- verilog/DataMemArbiter.sv
`timescale 1ns/100ps

module DataMemArbiter
    import Types::*;
(
    input  logic      i_clock,
    input  logic      i_rst,

    // Core requester
    input  logic      i_coreReq,
    input  WordIndex  i_coreAddr,
    input  logic      i_coreWrEnable,
    input  ByteStrobe i_coreWrStrobe,
    input  Data       i_coreWrData,
    output logic      o_coreGnt,
    output logic      o_coreAck,
    output Data       o_coreRdData,

    // Host requester
    input  logic      i_hostReq,
    input  WordIndex  i_hostAddr,
    input  logic      i_hostWrEnable,
    input  ByteStrobe i_hostWrStrobe,
    input  Data       i_hostWrData,
    output logic      o_hostGnt,
    output logic      o_hostAck,
    output Data       o_hostRdData,

    // Toward the memory
    output logic      o_memEnable,
    output WordIndex  o_memAddr,
    output logic      o_memWrEnable,
    output ByteStrobe o_memWrStrobe,
    output Data       o_memWrData,
    input  logic      i_memAck,
    input  Data       i_memRdData);

    logic lastHost;                     // Host won the last arbitration
    logic ownerHost;                    // Host owns the access now in memory

    // Round-robin, the loser of the last conflict wins the next
    assign o_coreGnt   = i_coreReq & (~i_hostReq | lastHost);
    assign o_hostGnt   = i_hostReq & (~i_coreReq | ~lastHost);
    assign o_memEnable = o_coreGnt | o_hostGnt;

    // Winner's request to memory
    assign o_memAddr     = o_hostGnt ? i_hostAddr     : i_coreAddr;
    assign o_memWrEnable = o_hostGnt ? i_hostWrEnable : i_coreWrEnable;
    assign o_memWrStrobe = o_hostGnt ? i_hostWrStrobe : i_coreWrStrobe;
    assign o_memWrData   = o_hostGnt ? i_hostWrData   : i_coreWrData;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            lastHost  <= 1'b0;
            ownerHost <= 1'b0;
        end else begin
            ownerHost <= o_hostGnt;                 // Steers next cycle's ack
            if (o_memEnable)
                lastHost <= o_hostGnt;
        end
    end

    // Ack routed to the owner, data shared
    assign o_coreAck    = i_memAck & ~ownerHost;
    assign o_hostAck    = i_memAck & ownerHost;
    assign o_coreRdData = i_memRdData;
    assign o_hostRdData = i_memRdData;

    // At most one grant per cycle
    assert property (@(posedge i_clock) disable iff (i_rst)
        $onehot0({o_coreGnt, o_hostGnt}));

    // Every granted access is acknowledged by the memory one cycle later
    assert property (@(posedge i_clock) disable iff (i_rst)
        o_memEnable |=> i_memAck);

endmodule

//--- verilog/DataMemory.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module DataMemory
    import Types::*;
(
    input  logic      i_clock,
    input  logic      i_rst,
    input  logic      i_enable,         // Access this cycle
    input  WordIndex  i_addr,
    input  logic      i_wrEnable,
    input  ByteStrobe i_wrStrobe,       // Byte lanes to write
    input  Data       i_wrData,
    output logic      o_ack,            // One cycle after i_enable
    output Data       o_rdData);

    Data mem [`MEM_WORDS];              // Word array

    // Byte-masked write, registered read of the old word
    always_ff @(posedge i_clock) begin
        if (i_enable) begin
            if (i_wrEnable) begin
                for (int b = 0; b < $bits(ByteStrobe); b++) begin
                    if (i_wrStrobe[b])
                        mem[i_addr][b*8 +: 8] <= i_wrData[b*8 +: 8];
                end
            end
            o_rdData <= mem[i_addr];
        end
    end

    always_ff @(posedge i_clock) begin
        if (i_rst)
            o_ack <= 1'b0;
        else
            o_ack <= i_enable;
    end

endmodule

//--- verilog/AxiLiteHostPort.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module AxiLiteHostPort
    import Types::*;
(
    input  logic      i_clock,
    input  logic      i_rst,

    // Write address and data
    input  logic      i_awvalid,
    input  Data       i_awaddr,
    output logic      o_awready,
    input  logic      i_wvalid,
    input  Data       i_wdata,
    input  ByteStrobe i_wstrb,
    output logic      o_wready,

    // Write response
    output logic      o_bvalid,
    output AxiResp    o_bresp,
    input  logic      i_bready,

    // Read address and data
    input  logic      i_arvalid,
    input  Data       i_araddr,
    output logic      o_arready,
    output logic      o_rvalid,
    output Data       o_rdata,
    output AxiResp    o_rresp,
    input  logic      i_rready,

    // Memory request side
    output logic      o_memReq,
    output WordIndex  o_memAddr,
    output logic      o_memWrEnable,
    output ByteStrobe o_memWrStrobe,
    output Data       o_memWrData,
    input  logic      i_memGnt,
    input  logic      i_memAck,
    input  Data       i_memRdData);

    HostState  state;
    logic      wrAccept;                // AW and W taken together
    logic      rdAccept;
    Data       reqAddr;
    logic      inRange;
    logic      isWrite;
    WordIndex  addrIdx;
    ByteStrobe wrStrb;
    Data       wrData;
    AxiResp    resp;
    Data       rdData;

    // ------------------------------
    // Address phase
    // ------------------------------

    assign wrAccept = (state == HOST_IDLE) & i_awvalid & i_wvalid;
    assign rdAccept = (state == HOST_IDLE) & ~wrAccept & i_arvalid;  // Write first
    assign reqAddr  = wrAccept ? i_awaddr : i_araddr;
    assign inRange  = reqAddr < (`MEM_WORDS * (`DATA_WIDTH / 8));

    assign o_awready = wrAccept;
    assign o_wready  = wrAccept;
    assign o_arready = rdAccept;

    always_ff @(posedge i_clock) begin
        if (i_rst) begin
            state <= HOST_IDLE;
        end else begin
            case (state)
                HOST_IDLE:
                    if (wrAccept || rdAccept)
                        state <= inRange ? HOST_WAIT_GRANT : HOST_RESP;  // Skip memory
                HOST_WAIT_GRANT:
                    if (i_memGnt) state <= HOST_WAIT_ACK;
                HOST_WAIT_ACK:
                    if (i_memAck) state <= HOST_RESP;
                HOST_RESP:
                    if ((isWrite && i_bready) || (!isWrite && i_rready))
                        state <= HOST_IDLE;
                default:
                    state <= HOST_IDLE;
            endcase
        end
    end

    // Transaction payload
    always_ff @(posedge i_clock) begin
        if (wrAccept || rdAccept) begin
            isWrite <= wrAccept;
            addrIdx <= reqAddr[`DATA_ADDR_WIDTH-1:2];
            wrData  <= i_wdata;
            wrStrb  <= i_wstrb;
            resp    <= inRange ? `AXI_OKAY : `AXI_SLVERR;
            rdData  <= '0;                          // Stays 0 on SLVERR
        end else if (state == HOST_WAIT_ACK && i_memAck && !isWrite) begin
            rdData  <= i_memRdData;
        end
    end

    // ------------------------------
    // Memory request and response
    // ------------------------------

    assign o_memReq      = (state == HOST_WAIT_GRANT);
    assign o_memAddr     = addrIdx;
    assign o_memWrEnable = isWrite;
    assign o_memWrStrobe = wrStrb;
    assign o_memWrData   = wrData;

    assign o_bvalid = (state == HOST_RESP) & isWrite;
    assign o_rvalid = (state == HOST_RESP) & ~isWrite;
    assign o_bresp  = resp;
    assign o_rresp  = resp;
    assign o_rdata  = rdData;

    // Only one response channel active
    assert property (@(posedge i_clock) disable iff (i_rst)
        !(o_bvalid && o_rvalid));

    // Read response held until the host takes it
    assert property (@(posedge i_clock) disable iff (i_rst)
        (o_rvalid && !i_rready) |=> o_rvalid && $stable(o_rdata) && $stable(o_rresp));

endmodule

//--- verilog/MemSubsystem.sv
`timescale 1ns/100ps

module MemSubsystem
    import Types::*;
(
    input  logic      i_clock,
    input  logic      i_rst,

    // Pipeline side of the memory stage
    input  logic      i_valid,
    input  InstAddr   i_pc,
    input  Data       i_result,
    input  Data       i_dataB,
    input  logic      i_memRdEnable,
    input  logic      i_memWrEnable,
    input  MemAccess  i_memAccess,
    input  WbSel      i_regWrDataSel,
    output Data       o_regWrData,
    output logic      o_done,
    output logic      o_stall,

    // AXI4-Lite host
    input  logic      i_awvalid,
    input  Data       i_awaddr,
    output logic      o_awready,
    input  logic      i_wvalid,
    input  Data       i_wdata,
    input  ByteStrobe i_wstrb,
    output logic      o_wready,
    output logic      o_bvalid,
    output AxiResp    o_bresp,
    input  logic      i_bready,
    input  logic      i_arvalid,
    input  Data       i_araddr,
    output logic      o_arready,
    output logic      o_rvalid,
    output Data       o_rdata,
    output AxiResp    o_rresp,
    input  logic      i_rready);

    // Core request set
    logic      coreReq, coreWrEnable, coreGnt, coreAck;
    WordIndex  coreAddr;
    ByteStrobe coreWrStrobe;
    Data       coreWrData, coreRdData;

    // Host request set
    logic      hostReq, hostWrEnable, hostGnt, hostAck;
    WordIndex  hostAddr;
    ByteStrobe hostWrStrobe;
    Data       hostWrData, hostRdData;

    // Arbiter to memory
    logic      memEnable, memWrEnable, memAck;
    WordIndex  memAddr;
    ByteStrobe memWrStrobe;
    Data       memWrData, memRdData;

    StageMEM stageMem (
        .i_clock        (i_clock),
        .i_rst          (i_rst),
        .i_valid        (i_valid),
        .i_pc           (i_pc),
        .i_result       (i_result),
        .i_dataB        (i_dataB),
        .i_memRdEnable  (i_memRdEnable),
        .i_memWrEnable  (i_memWrEnable),
        .i_memAccess    (i_memAccess),
        .i_regWrDataSel (i_regWrDataSel),
        .o_regWrData    (o_regWrData),
        .o_done         (o_done),
        .o_stall        (o_stall),
        .o_memReq       (coreReq),
        .o_memAddr      (coreAddr),
        .o_memWrEnable  (coreWrEnable),
        .o_memWrStrobe  (coreWrStrobe),
        .o_memWrData    (coreWrData),
        .i_memGnt       (coreGnt),
        .i_memAck       (coreAck),
        .i_memRdData    (coreRdData));

    AxiLiteHostPort hostPort (
        .i_clock       (i_clock),
        .i_rst         (i_rst),
        .i_awvalid     (i_awvalid),
        .i_awaddr      (i_awaddr),
        .o_awready     (o_awready),
        .i_wvalid      (i_wvalid),
        .i_wdata       (i_wdata),
        .i_wstrb       (i_wstrb),
        .o_wready      (o_wready),
        .o_bvalid      (o_bvalid),
        .o_bresp       (o_bresp),
        .i_bready      (i_bready),
        .i_arvalid     (i_arvalid),
        .i_araddr      (i_araddr),
        .o_arready     (o_arready),
        .o_rvalid      (o_rvalid),
        .o_rdata       (o_rdata),
        .o_rresp       (o_rresp),
        .i_rready      (i_rready),
        .o_memReq      (hostReq),
        .o_memAddr     (hostAddr),
        .o_memWrEnable (hostWrEnable),
        .o_memWrStrobe (hostWrStrobe),
        .o_memWrData   (hostWrData),
        .i_memGnt      (hostGnt),
        .i_memAck      (hostAck),
        .i_memRdData   (hostRdData));

    DataMemArbiter arbiter (
        .i_clock        (i_clock),
        .i_rst          (i_rst),
        .i_coreReq      (coreReq),
        .i_coreAddr     (coreAddr),
        .i_coreWrEnable (coreWrEnable),
        .i_coreWrStrobe (coreWrStrobe),
        .i_coreWrData   (coreWrData),
        .o_coreGnt      (coreGnt),
        .o_coreAck      (coreAck),
        .o_coreRdData   (coreRdData),
        .i_hostReq      (hostReq),
        .i_hostAddr     (hostAddr),
        .i_hostWrEnable (hostWrEnable),
        .i_hostWrStrobe (hostWrStrobe),
        .i_hostWrData   (hostWrData),
        .o_hostGnt      (hostGnt),
        .o_hostAck      (hostAck),
        .o_hostRdData   (hostRdData),
        .o_memEnable    (memEnable),
        .o_memAddr      (memAddr),
        .o_memWrEnable  (memWrEnable),
        .o_memWrStrobe  (memWrStrobe),
        .o_memWrData    (memWrData),
        .i_memAck       (memAck),
        .i_memRdData    (memRdData));

    DataMemory dataMemory (
        .i_clock    (i_clock),
        .i_rst      (i_rst),
        .i_enable   (memEnable),
        .i_addr     (memAddr),
        .i_wrEnable (memWrEnable),
        .i_wrStrobe (memWrStrobe),
        .i_wrData   (memWrData),
        .o_ack      (memAck),
        .o_rdData   (memRdData));

endmodule

//--- bench/ClockGen.sv
`timescale 1ns/100ps

module ClockGen (
    output logic o_clock,
    output logic o_rst);

    // 4 ns period
    initial begin
        o_clock = 1'b0;
        forever #2 o_clock = ~o_clock;
    end

    // Synchronous reset held over 4 rising edges
    initial begin
        o_rst = 1'b1;
        repeat (4) @(posedge o_clock);
        @(negedge o_clock);
        o_rst = 1'b0;                   // Released away from the active edge
    end

endmodule

//--- bench/MemSubsystemTb.sv
`timescale 1ns/100ps
`include "rv_consts.svh"

module MemSubsystemTb
    import Types::*;
();

    localparam int TIMEOUT   = 64;      // Cycles allowed per wait
    localparam int MEM_BYTES = `MEM_WORDS * (`DATA_WIDTH / 8);

    // Wait targets
    localparam int WAIT_WR_ADDR = 0;
    localparam int WAIT_RD_ADDR = 1;
    localparam int WAIT_BRESP   = 2;
    localparam int WAIT_RRESP   = 3;
    localparam int WAIT_DONE    = 4;

    logic      clock, rst;
    logic      valid, rdEn, wrEn, done, stall;
    InstAddr   pc;
    Data       result, dataB, regWrData;
    MemAccess  access;
    WbSel      wbSel;
    logic      awvalid, awready, wvalid, wready, bvalid, bready;
    logic      arvalid, arready, rvalid, rready;
    Data       awaddr, wdata, araddr, rdata;
    ByteStrobe wstrb;
    AxiResp    bresp, rresp;

    logic [7:0] mirror [MEM_BYTES];     // Expected memory image with one byte per entry
    MemAccess   accCodes [5] = '{`ACC_B, `ACC_H, `ACC_W, `ACC_BU, `ACC_HU};
    Data        expWb;                  // Value the pending core op must write back
    int         errors;
    int         timeouts;

    ClockGen clockGen (.o_clock(clock), .o_rst(rst));

    MemSubsystem dut_i (
        .i_clock(clock), .i_rst(rst),
        .i_valid(valid), .i_pc(pc), .i_result(result), .i_dataB(dataB),
        .i_memRdEnable(rdEn), .i_memWrEnable(wrEn), .i_memAccess(access),
        .i_regWrDataSel(wbSel), .o_regWrData(regWrData), .o_done(done), .o_stall(stall),
        .i_awvalid(awvalid), .i_awaddr(awaddr), .o_awready(awready),
        .i_wvalid(wvalid), .i_wdata(wdata), .i_wstrb(wstrb), .o_wready(wready),
        .o_bvalid(bvalid), .o_bresp(bresp), .i_bready(bready),
        .i_arvalid(arvalid), .i_araddr(araddr), .o_arready(arready),
        .o_rvalid(rvalid), .o_rdata(rdata), .o_rresp(rresp), .i_rready(rready));

    // ------------------------------
    // Reference model and checks
    // ------------------------------

    // Expected write-back from the mirror image
    function automatic Data expectedWb(MemAccess acc, Data addr, InstAddr pcIn, Data alu,
                                       WbSel sel);
        logic [7:0]  b;
        logic [15:0] h;
        Data         w;
        Data         ld;
        b = mirror[addr[9:0]];
        h = {mirror[{addr[9:1], 1'b1}], mirror[{addr[9:1], 1'b0}]};
        w = {mirror[{addr[9:2], 2'd3}], mirror[{addr[9:2], 2'd2}],
             mirror[{addr[9:2], 2'd1}], mirror[{addr[9:2], 2'd0}]};
        case (acc)
            `ACC_B:  ld = {{24{b[7]}}, b};      // Sign from bit 7
            `ACC_BU: ld = {24'h000000, b};
            `ACC_H:  ld = {{16{h[15]}}, h};
            `ACC_HU: ld = {16'h0000, h};
            default: ld = w;
        endcase
        case (sel)
            `WB_MEM: return ld;
            `WB_PC4: return pcIn + 32'd4;
            default: return alu;
        endcase
    endfunction

    function automatic int accessSize(MemAccess acc);
        case (acc)
            `ACC_B, `ACC_BU: return 1;
            `ACC_H, `ACC_HU: return 2;
            default:         return 4;
        endcase
    endfunction

    task automatic checkValue(input string name, input Data actual, input Data expected);
        if (actual !== expected) begin
            errors++;
            $display("error: %s is %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    // Write-back compared in every done cycle
    always @(posedge clock) begin
        if (!rst && done)
            checkValue("o_regWrData", regWrData, expWb);
    end

    // Bounded wait for one DUT event sampled on the rising edge
    task automatic waitFor(input int target, input string what, output logic ok);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < TIMEOUT) begin
            @(posedge clock);
            case (target)
                WAIT_WR_ADDR: seen = awready & wready;
                WAIT_RD_ADDR: seen = arready;
                WAIT_BRESP:   seen = bvalid;
                WAIT_RRESP:   seen = rvalid;
                default: begin
                    seen = done;
                    if (!seen)
                        checkValue("o_stall", 32'(stall), 32'h1);   // Held until the ack
                end
            endcase
            cycles++;
        end
        ok = seen;
        if (!seen) begin
            timeouts++;
            $display("timeout: %s did not arrive within %0d cycles at %0t",
                     what, TIMEOUT, $time);
        end
    endtask

    // ------------------------------
    // Host and core drivers
    // ------------------------------

    task automatic hostWrite(input Data addr, input Data data, input ByteStrobe strb,
                             input int respDelay);
        logic ok;
        int   i;
        @(negedge clock);
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        wstrb   = strb;
        waitFor(WAIT_WR_ADDR, "AW/W ready", ok);
        @(negedge clock);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        if (addr < MEM_BYTES) begin                     // Out of range leaves memory alone
            for (i = 0; i < 4; i++)
                if (strb[i]) mirror[{addr[9:2], 2'(i)}] = data[i*8 +: 8];
        end
        waitFor(WAIT_BRESP, "bvalid", ok);
        if (ok)
            checkValue("o_bresp", 32'(bresp),
                       (addr < MEM_BYTES) ? 32'(`AXI_OKAY) : 32'(`AXI_SLVERR));
        repeat (respDelay) @(negedge clock);            // Host back-pressure
        @(negedge clock);
        bready = 1'b1;
        @(posedge clock);
        checkValue("o_bvalid", 32'(bvalid), 32'h1);     // Still held when taken
        @(negedge clock);
        bready = 1'b0;
    endtask

    task automatic hostRead(input Data addr, input int respDelay);
        logic ok;
        Data  expData;
        @(negedge clock);
        arvalid = 1'b1;
        araddr  = addr;
        waitFor(WAIT_RD_ADDR, "arready", ok);
        expData = (addr < MEM_BYTES) ? expectedWb(`ACC_W, addr, '0, '0, `WB_MEM) : '0;
        @(negedge clock);
        arvalid = 1'b0;
        waitFor(WAIT_RRESP, "rvalid", ok);
        if (ok) begin
            checkValue("o_rdata", rdata, expData);
            checkValue("o_rresp", 32'(rresp),
                       (addr < MEM_BYTES) ? 32'(`AXI_OKAY) : 32'(`AXI_SLVERR));
        end
        repeat (respDelay) @(negedge clock);
        @(negedge clock);
        rready = 1'b1;
        @(posedge clock);
        checkValue("o_rvalid", 32'(rvalid), 32'h1);
        @(negedge clock);
        rready = 1'b0;
    endtask

    // One instruction through the memory stage
    task automatic coreOp(input logic rd, input logic wr, input MemAccess acc, input Data res,
                          input Data storeData, input WbSel sel, input InstAddr pcIn);
        logic ok;
        int   i;
        @(negedge clock);
        valid  = 1'b1;
        rdEn   = rd;
        wrEn   = wr;
        access = acc;
        result = res;
        dataB  = storeData;
        wbSel  = sel;
        pc     = pcIn;
        expWb  = expectedWb(acc, res, pcIn, res, sel);
        if (!rd && !wr) begin
            @(posedge clock);                           // Same-cycle completion
            checkValue("o_done", 32'(done), 32'h1);
            checkValue("o_stall", 32'(stall), 32'h0);
        end else begin
            waitFor(WAIT_DONE, "o_done", ok);
            if (ok)
                checkValue("o_stall", 32'(stall), 32'h0);   // Released in the ack cycle
            if (ok && wr) begin
                for (i = 0; i < accessSize(acc); i++)
                    mirror[res[9:0] + 10'(i)] = storeData[i*8 +: 8];
            end
        end
        @(negedge clock);
        valid = 1'b0;
        rdEn  = 1'b0;
        wrEn  = 1'b0;
    endtask

    task automatic randomCoreOp(input int wordBase, input int wordSpan);
        MemAccess acc;
        Data      addr;
        int       size;
        acc  = accCodes[$urandom_range(4)];
        size = accessSize(acc);
        addr = Data'((wordBase + int'($urandom_range(wordSpan - 1))) * 4
                     + int'($urandom_range(4 / size - 1)) * size);
        if ($urandom_range(1) == 1)
            coreOp(1'b0, 1'b1, acc, addr, $urandom, `WB_ALU, $urandom & 32'hfffffffc);
        else
            coreOp(1'b1, 1'b0, acc, addr, '0, `WB_MEM, $urandom & 32'hfffffffc);
    endtask

    task automatic randomHostOp(input int wordBase, input int wordSpan);
        Data addr;
        addr = Data'((wordBase + int'($urandom_range(wordSpan - 1))) * 4);
        if ($urandom_range(1) == 1)
            hostWrite(addr, $urandom, ByteStrobe'($urandom_range(15)), int'($urandom_range(3)));
        else
            hostRead(addr, int'($urandom_range(3)));
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin
        Data r;
        int  i, k, n, off;
        errors   = 0;
        timeouts = 0;
        expWb    = '0;
        void'($urandom(12212));
        {valid, rdEn, wrEn, awvalid, wvalid, bready, arvalid, rready} = '0;
        {pc, result, dataB, awaddr, wdata, araddr} = '0;
        access = `ACC_W;
        wbSel  = `WB_ALU;
        wstrb  = '0;

        @(negedge clock);
        k = 0;
        while (rst !== 1'b0 && k < TIMEOUT) begin
            @(negedge clock);
            k++;
        end
        if (rst !== 1'b0) begin
            timeouts++;
            $display("timeout: reset was never released");
        end

        for (i = 0; i < `MEM_WORDS; i++)                     // Known memory image
            hostWrite(Data'(i * 4), $urandom, 4'hf, 0);

        for (i = 0; i < 40; i++) begin                       // Host write then read back
            r = Data'($urandom_range(`MEM_WORDS - 1) * 4);
            hostWrite(r, $urandom, ByteStrobe'($urandom_range(15)), int'($urandom_range(3)));
            hostRead(r, int'($urandom_range(3)));
        end

        for (k = 0; k < 5; k++) begin                        // Every load at every offset
            for (n = 0; n < 6; n++) begin
                r = Data'($urandom_range(`MEM_WORDS - 1) * 4);
                for (off = 0; off < 4; off += accessSize(accCodes[k]))
                    coreOp(1'b1, 1'b0, accCodes[k], r + Data'(off), '0, `WB_MEM, $urandom);
            end
        end

        for (i = 0; i < 24; i++) begin                       // Narrow stores touch their lanes only
            k = (i % 2 == 0) ? 0 : 1;
            r = Data'($urandom_range(`MEM_WORDS - 1) * 4);
            off = int'($urandom_range(4 / accessSize(accCodes[k]) - 1)) * accessSize(accCodes[k]);
            coreOp(1'b0, 1'b1, accCodes[k], r + Data'(off), $urandom, `WB_ALU, $urandom);
            coreOp(1'b1, 1'b0, `ACC_W, r, '0, `WB_MEM, $urandom);
            hostRead(r, 0);
        end

        for (i = 0; i < 20; i++)                             // No memory access
            coreOp(1'b0, 1'b0, `ACC_W, $urandom, $urandom,
                   (i % 2 == 0) ? `WB_ALU : `WB_PC4, $urandom);

        fork                                                 // Contention on disjoint halves
            for (int c = 0; c < 40; c++)
                randomCoreOp(0, `MEM_WORDS / 2);
            for (int h = 0; h < 40; h++)
                randomHostOp(`MEM_WORDS / 2, `MEM_WORDS / 2);
        join

        for (i = 0; i < 6; i++) begin                        // Beyond the memory
            r = Data'(MEM_BYTES) + ($urandom & 32'h0000fffc);
            hostWrite(r, $urandom, 4'hf, 0);
            hostRead(r, 0);
            hostRead(r & Data'(MEM_BYTES - 1), 0);           // Aliased word unchanged
        end

        repeat (4) @(negedge clock);
        $display("Run finished with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
+incdir+verilog
verilog/Types.sv
verilog/StageMEM.sv
verilog/DataMemArbiter.sv
verilog/DataMemory.sv
verilog/AxiLiteHostPort.sv
verilog/MemSubsystem.sv
bench/ClockGen.sv
bench/MemSubsystemTb.sv

//--- Makefile
# Verilator simulation of the memory subsystem

VERILATOR ?= verilator
TOP       ?= MemSubsystemTb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

# Build, run, then decide from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "No result line in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
